//--- verilog/lda_pkg.sv
package lda_pkg;

  // Coordinate and colour widths
  localparam int X_BITS = 9;
  localparam int Y_BITS = 8;
  localparam int COLOR_BITS = 3;

  // One line request from the register block
  typedef struct packed {
    logic [X_BITS-1:0]     x0;
    logic [Y_BITS-1:0]     y0;
    logic [X_BITS-1:0]     x1;
    logic [Y_BITS-1:0]     y1;
    logic [COLOR_BITS-1:0] color;
  } line_t;

  // One plotted pixel
  typedef struct packed {
    logic [X_BITS-1:0]     x;
    logic [Y_BITS-1:0]     y;
    logic [COLOR_BITS-1:0] color;
  } pixel_t;

  // Word addresses of the slave port
  typedef enum logic [2:0] {
    REG_X0      = 3'd0,
    REG_Y0      = 3'd1,
    REG_X1      = 3'd2,
    REG_Y1      = 3'd3,
    REG_COLOR   = 3'd4,
    REG_START   = 3'd5,
    REG_FB_ADDR = 3'd6,
    REG_FB_DATA = 3'd7
  } lda_reg_e;

  typedef enum logic [1:0] {
    IDLE,
    DRAW,
    ACK
  } lda_state_e;

endpackage

//--- verilog/lda_avalon_slave_controller.sv
`timescale 1ns/1ns

module lda_avalon_slave_controller (
  input  logic                               i_clk,
  input  logic                               i_rst,

  // Avalon-MM slave
  input  lda_pkg::lda_reg_e                  i_address,
  input  logic                               i_read,
  input  logic                               i_write,
  input  logic [31:0]                        i_writedata,
  output logic [31:0]                        o_readdata,
  output logic                               o_waitrequest,

  // Line request to the engine
  output lda_pkg::line_t                     o_line,
  output logic                               o_line_req,
  input  logic                               i_line_ack,

  // Frame-buffer readback
  output logic [lda_pkg::X_BITS-1:0]         o_fb_x,
  output logic [lda_pkg::Y_BITS-1:0]         o_fb_y,
  input  logic [lda_pkg::COLOR_BITS-1:0]     i_fb_color
);

  import lda_pkg::*;

  localparam int FB_ADDR_BITS = X_BITS + Y_BITS;

  line_t                   host_line_q;
  line_t                   active_line_q;
  logic [FB_ADDR_BITS-1:0] fb_addr_q;
  logic                    req_q;
  logic                    fb_wait_q;
  logic [15:0]             done_count_q;

  logic                    busy;
  logic                    start_wr;
  logic                    start_go;
  logic                    start_stall;
  logic                    fb_rd;
  logic                    fb_stall;
  logic                    wr_accept;

  // Line in flight until ack has returned low
  assign busy = req_q | i_line_ack;

  assign start_wr    = i_write && (i_address == REG_START);
  assign start_go    = start_wr && !busy;
  assign start_stall = start_wr && busy;

  // Frame-buffer data needs one cycle for the memory read
  assign fb_rd    = i_read && (i_address == REG_FB_DATA);
  assign fb_stall = fb_rd && !fb_wait_q;

  assign o_waitrequest = start_stall | fb_stall;
  assign wr_accept     = i_write && !o_waitrequest;

  // Host-visible line and readback address registers
  always_ff @(posedge i_clk) begin
    if (wr_accept) begin
      case (i_address)
        REG_X0:      host_line_q.x0 <= i_writedata[X_BITS-1:0];
        REG_Y0:      host_line_q.y0 <= i_writedata[Y_BITS-1:0];
        REG_X1:      host_line_q.x1 <= i_writedata[X_BITS-1:0];
        REG_Y1:      host_line_q.y1 <= i_writedata[Y_BITS-1:0];
        REG_COLOR:   host_line_q.color <= i_writedata[COLOR_BITS-1:0];
        REG_FB_ADDR: fb_addr_q <= i_writedata[FB_ADDR_BITS-1:0];
        default:     ;
      endcase
    end
  end

  // Snapshot for the engine, so the host may load the next line early
  always_ff @(posedge i_clk) begin
    if (start_go) begin
      active_line_q <= host_line_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      req_q        <= 1'b0;
      fb_wait_q    <= 1'b0;
      done_count_q <= '0;
    end else begin
      if (start_go) begin
        req_q <= 1'b1;
      end else if (i_line_ack) begin
        req_q <= 1'b0;
      end
      // Ack still high after req dropped is the last phase
      if (!req_q && i_line_ack) begin
        done_count_q <= done_count_q + 16'd1;
      end
      fb_wait_q <= fb_stall;
    end
  end

  always_comb begin
    o_readdata = '0;
    case (i_address)
      REG_X0:      o_readdata[X_BITS-1:0] = host_line_q.x0;
      REG_Y0:      o_readdata[Y_BITS-1:0] = host_line_q.y0;
      REG_X1:      o_readdata[X_BITS-1:0] = host_line_q.x1;
      REG_Y1:      o_readdata[Y_BITS-1:0] = host_line_q.y1;
      REG_COLOR:   o_readdata[COLOR_BITS-1:0] = host_line_q.color;
      REG_START: begin
        o_readdata[0]     = busy;
        o_readdata[31:16] = done_count_q;
      end
      REG_FB_ADDR: o_readdata[FB_ADDR_BITS-1:0] = fb_addr_q;
      REG_FB_DATA: o_readdata[COLOR_BITS-1:0] = i_fb_color;
      default:     o_readdata = '0;
    endcase
  end

  assign o_line     = active_line_q;
  assign o_line_req = req_q;

  // Readback address is y above x
  assign o_fb_x = fb_addr_q[X_BITS-1:0];
  assign o_fb_y = fb_addr_q[FB_ADDR_BITS-1:X_BITS];

endmodule

//--- verilog/line_drawing_algorithm.sv
`timescale 1ns/1ns

module line_drawing_algorithm (
  input  logic            i_clk,
  input  logic            i_rst,

  // Line request
  input  lda_pkg::line_t  i_line,
  input  logic            i_line_req,
  output logic            o_line_ack,

  // Plot stream
  output lda_pkg::pixel_t o_pixel,
  output logic            o_plot
);

  import lda_pkg::*;

  // Room for 2*err over the full coordinate range
  localparam int E_BITS = X_BITS + 3;

  lda_state_e               state_q;

  logic [X_BITS-1:0]        x_q;
  logic [Y_BITS-1:0]        y_q;
  logic [X_BITS-1:0]        end_x_q;
  logic [Y_BITS-1:0]        end_y_q;
  logic [COLOR_BITS-1:0]    color_q;
  logic signed [E_BITS-1:0] dx_q;
  logic signed [E_BITS-1:0] dy_q;
  logic signed [E_BITS-1:0] err_q;
  logic                     sx_neg_q;
  logic                     sy_neg_q;

  logic signed [E_BITS-1:0] diff_x;
  logic signed [E_BITS-1:0] diff_y;
  logic signed [E_BITS-1:0] abs_x;
  logic signed [E_BITS-1:0] abs_y;
  logic signed [E_BITS-1:0] err2;
  logic signed [E_BITS-1:0] err_next;
  logic                     step_x;
  logic                     step_y;
  logic                     at_end;
  logic                     load;

  // Setup terms from the incoming line
  assign diff_x = E_BITS'(i_line.x1) - E_BITS'(i_line.x0);
  assign diff_y = E_BITS'(i_line.y1) - E_BITS'(i_line.y0);
  assign abs_x  = diff_x[E_BITS-1] ? -diff_x : diff_x;
  assign abs_y  = diff_y[E_BITS-1] ? -diff_y : diff_y;

  // Per-pixel step decision
  assign err2   = err_q <<< 1;
  assign step_x = (err2 >= dy_q);
  assign step_y = (err2 <= dx_q);

  always_comb begin
    err_next = err_q;
    if (step_x) begin
      err_next = err_next + dy_q;
    end
    if (step_y) begin
      err_next = err_next + dx_q;
    end
  end

  assign at_end = (x_q == end_x_q) && (y_q == end_y_q);
  assign load   = (state_q == IDLE) && i_line_req;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_line_req) begin
            state_q <= DRAW;
          end
        end
        DRAW: begin
          if (at_end) begin
            state_q <= ACK;
          end
        end
        ACK: begin
          // Hold ack until the requester lets go
          if (!i_line_req) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      x_q      <= i_line.x0;
      y_q      <= i_line.y0;
      end_x_q  <= i_line.x1;
      end_y_q  <= i_line.y1;
      color_q  <= i_line.color;
      dx_q     <= abs_x;
      dy_q     <= -abs_y;
      err_q    <= abs_x - abs_y;
      sx_neg_q <= diff_x[E_BITS-1];
      sy_neg_q <= diff_y[E_BITS-1];
    end else if ((state_q == DRAW) && !at_end) begin
      err_q <= err_next;
      if (step_x) begin
        x_q <= sx_neg_q ? x_q - X_BITS'(1) : x_q + X_BITS'(1);
      end
      if (step_y) begin
        y_q <= sy_neg_q ? y_q - Y_BITS'(1) : y_q + Y_BITS'(1);
      end
    end
  end

  // One pixel for every DRAW cycle
  assign o_plot        = (state_q == DRAW);
  assign o_line_ack    = (state_q == ACK);
  assign o_pixel.x     = x_q;
  assign o_pixel.y     = y_q;
  assign o_pixel.color = color_q;

endmodule

//--- verilog/pixel_frame_buffer.sv
`timescale 1ns/1ns

module pixel_frame_buffer #(
  parameter int SCREEN_W = 320,
  parameter int SCREEN_H = 240
) (
  input  logic                            i_clk,

  // Write side, from the plot stream
  input  lda_pkg::pixel_t                 i_pixel,
  input  logic                            i_plot,

  // Read side, from the register block
  input  logic [lda_pkg::X_BITS-1:0]      i_rd_x,
  input  logic [lda_pkg::Y_BITS-1:0]      i_rd_y,
  output logic [lda_pkg::COLOR_BITS-1:0]  o_rd_color
);

  import lda_pkg::*;

  localparam int DEPTH     = SCREEN_W * SCREEN_H;
  localparam int ADDR_BITS = $clog2(DEPTH);

  logic [COLOR_BITS-1:0] mem [DEPTH];

  logic                  wr_on_screen;
  logic                  rd_on_screen;
  logic [ADDR_BITS-1:0]  wr_addr;
  logic [ADDR_BITS-1:0]  rd_addr;

  // Row-major layout
  assign wr_on_screen = (int'(i_pixel.x) < SCREEN_W) && (int'(i_pixel.y) < SCREEN_H);
  assign rd_on_screen = (int'(i_rd_x) < SCREEN_W) && (int'(i_rd_y) < SCREEN_H);
  assign wr_addr      = ADDR_BITS'(int'(i_pixel.y) * SCREEN_W + int'(i_pixel.x));
  assign rd_addr      = ADDR_BITS'(int'(i_rd_y) * SCREEN_W + int'(i_rd_x));

  // Off-screen plots are dropped
  always_ff @(posedge i_clk) begin
    if (i_plot && wr_on_screen) begin
      mem[wr_addr] <= i_pixel.color;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_on_screen) begin
      o_rd_color <= mem[rd_addr];
    end else begin
      o_rd_color <= '0;
    end
  end

endmodule

//--- verilog/lda_avalon_interface.sv
`timescale 1ns/1ns

module lda_avalon_interface #(
  parameter int SCREEN_W = 320,
  parameter int SCREEN_H = 240
) (
  input  logic            i_clk,
  input  logic            i_rst,

  // Avalon-MM slave
  input  logic [2:0]      i_avs_address,
  input  logic            i_avs_read,
  input  logic            i_avs_write,
  input  logic [31:0]     i_avs_writedata,
  output logic [31:0]     o_avs_readdata,
  output logic            o_avs_waitrequest,

  // Plot stream
  output lda_pkg::pixel_t o_pixel,
  output logic            o_plot
);

  import lda_pkg::*;

  lda_reg_e              avs_address;
  line_t                 line;
  logic                  line_req;
  logic                  line_ack;
  logic [X_BITS-1:0]     fb_x;
  logic [Y_BITS-1:0]     fb_y;
  logic [COLOR_BITS-1:0] fb_color;
  pixel_t                pixel;
  logic                  plot;

  assign avs_address = lda_reg_e'(i_avs_address);

  lda_avalon_slave_controller m_lda_avalon_slave_controller (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_address     (avs_address),
    .i_read        (i_avs_read),
    .i_write       (i_avs_write),
    .i_writedata   (i_avs_writedata),
    .o_readdata    (o_avs_readdata),
    .o_waitrequest (o_avs_waitrequest),
    .o_line        (line),
    .o_line_req    (line_req),
    .i_line_ack    (line_ack),
    .o_fb_x        (fb_x),
    .o_fb_y        (fb_y),
    .i_fb_color    (fb_color)
  );

  line_drawing_algorithm m_line_drawing_algorithm (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_line     (line),
    .i_line_req (line_req),
    .o_line_ack (line_ack),
    .o_pixel    (pixel),
    .o_plot     (plot)
  );

  pixel_frame_buffer #(
    .SCREEN_W (SCREEN_W),
    .SCREEN_H (SCREEN_H)
  ) m_pixel_frame_buffer (
    .i_clk      (i_clk),
    .i_pixel    (pixel),
    .i_plot     (plot),
    .i_rd_x     (fb_x),
    .i_rd_y     (fb_y),
    .o_rd_color (fb_color)
  );

  assign o_pixel = pixel;
  assign o_plot  = plot;

endmodule

//--- verification/lda_asserts.sv
`timescale 1ns/1ns

module lda_asserts (
  input logic i_clk,
  input logic i_rst,
  input logic i_line_req,
  input logic i_line_ack,
  input logic i_plot,
  input logic i_waitrequest
);

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(i_line_ack) |-> i_line_req)
    else $error("line ack rose while req was low");

  // Requester keeps req up until ack has arrived
  req_holds_for_ack: assert property (@(posedge i_clk) disable iff (i_rst)
    $fell(i_line_req) |-> $past(i_line_ack))
    else $error("line req fell before ack rose");

  // Draw phase is req high with ack still low
  plot_only_in_draw: assert property (@(posedge i_clk) disable iff (i_rst)
    i_plot |-> (i_line_req && !i_line_ack))
    else $error("plot high outside the draw phase of the handshake");

  wait_low_after_reset: assert property (@(posedge i_clk)
    $fell(i_rst) |-> !i_waitrequest)
    else $error("waitrequest high in the cycle after reset");

endmodule

bind lda_avalon_interface lda_asserts u_lda_asserts (
  .i_clk         (i_clk),
  .i_rst         (i_rst),
  .i_line_req    (line_req),
  .i_line_ack    (line_ack),
  .i_plot        (plot),
  .i_waitrequest (o_avs_waitrequest)
);

//--- verification/lda_tb.sv
`timescale 1ns/1ns

module lda_tb;

  import lda_pkg::*;

  localparam int SCREEN_W   = 320;
  localparam int SCREEN_H   = 240;
  localparam int CLK_PERIOD = 4;
  localparam int NUM_LINES  = 49;
  // Full-width walk plus register traffic for every line
  localparam int MAX_CYCLES = NUM_LINES * (SCREEN_W + 40) + 2000;

  logic        clk;
  logic        rst;
  logic [2:0]  avs_address;
  logic        avs_rd;
  logic        avs_wr;
  logic [31:0] avs_writedata;
  logic [31:0] avs_readdata;
  logic        avs_waitrequest;
  pixel_t      pixel;
  logic        plot;

  pixel_t      plot_q[$];
  pixel_t      exp_q[$];
  logic [31:0] rng_state;
  int          cycle_count = 0;
  int          lines_done;
  int          tests_run;
  int          tests_failed;
  int          total_errors;

  lda_avalon_interface #(
    .SCREEN_W (SCREEN_W),
    .SCREEN_H (SCREEN_H)
  ) i_lda_avalon_interface (
    .i_clk             (clk),
    .i_rst             (rst),
    .i_avs_address     (avs_address),
    .i_avs_read        (avs_rd),
    .i_avs_write       (avs_wr),
    .i_avs_writedata   (avs_writedata),
    .o_avs_readdata    (avs_readdata),
    .o_avs_waitrequest (avs_waitrequest),
    .o_pixel           (pixel),
    .o_plot            (plot)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Plot stream is stable mid-cycle
  always @(negedge clk) begin
    if (!rst && plot) begin
      plot_q.push_back(pixel);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: cycle limit reached before the tests finished");
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // Called just after a falling edge with the request driven
  task automatic wait_accept(output int waits);
    waits = 0;
    #1;
    while (avs_waitrequest) begin
      waits++;
      @(negedge clk);
      #1;
    end
  endtask

  task automatic avs_write(input logic [2:0] addr, input logic [31:0] data, output int waits);
    @(negedge clk);
    avs_address   = addr;
    avs_writedata = data;
    avs_wr        = 1'b1;
    wait_accept(waits);
    @(posedge clk);
    @(negedge clk);
    avs_wr = 1'b0;
  endtask

  task automatic avs_read(input logic [2:0] addr, output logic [31:0] data);
    int waits;
    @(negedge clk);
    avs_address = addr;
    avs_rd      = 1'b1;
    wait_accept(waits);
    data = avs_readdata;
    @(posedge clk);
    @(negedge clk);
    avs_rd = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    status = 32'h1;
    while (status[0]) begin
      avs_read(REG_START, status);
    end
  endtask

  // Reference walk, appended to exp_q
  task automatic build_expected(input int x0, y0, x1, y1, color);
    int     x;
    int     y;
    int     dx;
    int     dy;
    int     sx;
    int     sy;
    int     err;
    int     e2;
    logic   done;
    pixel_t px;
    x    = x0;
    y    = y0;
    dx   = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy   = (y1 > y0) ? y0 - y1 : y1 - y0;
    sx   = (x0 < x1) ? 1 : -1;
    sy   = (y0 < y1) ? 1 : -1;
    err  = dx + dy;
    done = 1'b0;
    while (!done) begin
      px.x     = X_BITS'(x);
      px.y     = Y_BITS'(y);
      px.color = COLOR_BITS'(color);
      exp_q.push_back(px);
      if (x == x1 && y == y1) begin
        done = 1'b1;
      end else begin
        e2 = 2 * err;
        if (e2 >= dy) begin
          err = err + dy;
          x   = x + sx;
        end
        if (e2 <= dx) begin
          err = err + dx;
          y   = y + sy;
        end
      end
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual, inout int errs);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, got %h", name, expected, actual);
      errs++;
    end
  endtask

  task automatic compare_stream(inout int errs);
    int n;
    if (plot_q.size() != exp_q.size()) begin
      $display("** Error plot count: expected %h, got %h", exp_q.size(), plot_q.size());
      errs++;
    end
    n = (plot_q.size() < exp_q.size()) ? plot_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      if (plot_q[i] !== exp_q[i]) begin
        $display("** Error o_pixel at index %0d: expected x=%h y=%h color=%h, ",
                 "got x=%h y=%h color=%h",
                 i, exp_q[i].x, exp_q[i].y, exp_q[i].color,
                 plot_q[i].x, plot_q[i].y, plot_q[i].color);
        errs++;
        break;
      end
    end
  endtask

  task automatic load_line(input int x0, y0, x1, y1, color);
    int waits;
    avs_write(REG_X0, x0, waits);
    avs_write(REG_Y0, y0, waits);
    avs_write(REG_X1, x1, waits);
    avs_write(REG_Y1, y1, waits);
    avs_write(REG_COLOR, color, waits);
  endtask

  task automatic draw_line(input int x0, y0, x1, y1, color, inout int errs);
    int          waits;
    logic [31:0] status;
    plot_q.delete();
    exp_q.delete();
    build_expected(x0, y0, x1, y1, color);
    load_line(x0, y0, x1, y1, color);
    avs_write(REG_START, 32'h1, waits);
    lines_done++;
    wait_idle();
    avs_read(REG_START, status);
    check_eq("REG_START count", 32'(lines_done), {16'h0, status[31:16]}, errs);
    compare_stream(errs);
  endtask

  task automatic finish_test(input string name, input int errs);
    tests_run++;
    total_errors += errs;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errs);
      tests_failed++;
    end
  endtask

  task automatic write_readback(input logic [2:0] addr, input string name,
                                input logic [31:0] mask, inout int errs);
    logic [31:0] value;
    logic [31:0] data;
    int          waits;
    value = next_random();
    avs_write(addr, value, waits);
    avs_read(addr, data);
    check_eq(name, value & mask, data, errs);
  endtask

  task automatic test_registers();
    int          errs;
    logic [31:0] data;
    errs = 0;
    avs_read(REG_START, data);
    check_eq("REG_START", 32'h0, data, errs);
    write_readback(REG_X0, "REG_X0", 32'h1ff, errs);
    write_readback(REG_Y0, "REG_Y0", 32'hff, errs);
    write_readback(REG_X1, "REG_X1", 32'h1ff, errs);
    write_readback(REG_Y1, "REG_Y1", 32'hff, errs);
    write_readback(REG_COLOR, "REG_COLOR", 32'h7, errs);
    // y above x in the readback address
    write_readback(REG_FB_ADDR, "REG_FB_ADDR", 32'h1ffff, errs);
    finish_test("registers", errs);
  endtask

  task automatic test_directed_lines();
    int errs;
    errs = 0;
    draw_line(10, 50, 90, 50, 3, errs);
    draw_line(200, 10, 200, 120, 6, errs);
    draw_line(7, 7, 7, 7, 1, errs);
    draw_line(150, 140, 100, 90, 4, errs);
    finish_test("directed lines", errs);
  endtask

  task automatic test_random_lines();
    int errs;
    int x0;
    int y0;
    int x1;
    int y1;
    int color;
    errs = 0;
    for (int i = 0; i < 40; i++) begin
      x0    = int'(next_random() % SCREEN_W);
      y0    = int'(next_random() % SCREEN_H);
      x1    = int'(next_random() % SCREEN_W);
      y1    = int'(next_random() % SCREEN_H);
      color = int'(next_random() % 8);
      draw_line(x0, y0, x1, y1, color, errs);
    end
    finish_test("random lines", errs);
  endtask

  task automatic test_back_pressure();
    int          errs;
    int          waits;
    int          first_len;
    logic [31:0] status;
    errs = 0;
    plot_q.delete();
    exp_q.delete();
    build_expected(0, 0, 150, 10, 2);
    first_len = exp_q.size();
    build_expected(5, 100, 60, 200, 5);
    load_line(0, 0, 150, 10, 2);
    avs_write(REG_START, 32'h1, waits);
    // Next line loads while the first one is still drawing
    load_line(5, 100, 60, 200, 5);
    avs_write(REG_START, 32'h1, waits);
    if (waits == 0) begin
      $display("Second start write was accepted without waiting while a line was drawing");
      errs++;
    end
    check_eq("plot count at second start", 32'(first_len), 32'(plot_q.size()), errs);
    lines_done += 2;
    wait_idle();
    avs_read(REG_START, status);
    check_eq("REG_START count", 32'(lines_done), {16'h0, status[31:16]}, errs);
    compare_stream(errs);
    finish_test("back pressure", errs);
  endtask

  task automatic check_readback(input logic [31:0] color, inout int errs);
    int          idx[3];
    int          waits;
    logic [31:0] data;
    pixel_t      px;
    idx[0] = 0;
    idx[1] = exp_q.size() / 2;
    idx[2] = exp_q.size() - 1;
    for (int i = 0; i < 3; i++) begin
      px = exp_q[idx[i]];
      avs_write(REG_FB_ADDR, {15'h0, px.y, px.x}, waits);
      avs_read(REG_FB_DATA, data);
      check_eq("REG_FB_DATA", color, data, errs);
    end
  endtask

  task automatic test_frame_buffer();
    int          errs;
    int          waits;
    logic [31:0] data;
    errs = 0;
    draw_line(10, 20, 60, 45, 5, errs);
    check_readback(32'h5, errs);
    draw_line(10, 20, 60, 45, 2, errs);
    check_readback(32'h2, errs);
    // On-screen pixel at the row-major address of (400, 10)
    draw_line(80, 11, 80, 11, 7, errs);
    avs_write(REG_FB_ADDR, {15'h0, 8'd10, 9'd400}, waits);
    avs_read(REG_FB_DATA, data);
    check_eq("REG_FB_DATA off screen x", 32'h0, data, errs);
    avs_write(REG_FB_ADDR, {15'h0, 8'd250, 9'd10}, waits);
    avs_read(REG_FB_DATA, data);
    check_eq("REG_FB_DATA off screen y", 32'h0, data, errs);
    finish_test("frame buffer", errs);
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    avs_address   = 3'd0;
    avs_rd        = 1'b0;
    avs_wr        = 1'b0;
    avs_writedata = 32'h0;
    rng_state     = 32'd4;
    lines_done    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    total_errors  = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_registers();
    test_directed_lines();
    test_random_lines();
    test_back_pressure();
    test_frame_buffer();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/lda_pkg.sv
verilog/lda_avalon_slave_controller.sv
verilog/line_drawing_algorithm.sv
verilog/pixel_frame_buffer.sv
verilog/lda_avalon_interface.sv
verification/lda_asserts.sv
verification/lda_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module lda_tb \
  -f filelist.f \
  -o lda_tb_sim

sim_status=0
sim_output=$(./obj_dir/lda_tb_sim) || sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "=== PASS ===" <<< "$sim_output"; then
  exit 0
fi
exit 1
